// File: Bender.yml
package:
  name: mem_stage

sources:
  - hdl/mem_pkg.sv
  - hdl/mem_req_stage.sv
  - hdl/mem_pipe_reg.sv
  - hdl/data_ram_ctrl.sv
  - hdl/mem_resp_stage.sv
  - hdl/mem_stage_top.sv
  - target: test
    files:
      - verif/mem_stage_tb.sv

// File: filelist.f
hdl/mem_pkg.sv
hdl/mem_req_stage.sv
hdl/mem_pipe_reg.sv
hdl/data_ram_ctrl.sv
hdl/mem_resp_stage.sv
hdl/mem_stage_top.sv
verif/mem_stage_tb.sv

// File: hdl/data_ram_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module data_ram_ctrl
    import mem_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              req_valid,
    input  wire logic              req_op,
    input  wire logic [xlen-1:0]   req_addr,
    input  wire logic [strb_w-1:0] req_strb,
    input  wire logic [xlen-1:0]   req_wdata,
    output logic                   data_valid,
    output logic [xlen-1:0]        r_data,
    output logic [exp_w-1:0]       ram_exception,
    output logic [xlen-1:0]        ram_badv
);

    logic [xlen-1:0]       mem [ram_words];
    logic [ram_lat_w-1:0]  cnt;       // cycles left until data_valid
    logic                  in_range;
    logic                  pending;
    logic [ram_addr_w-1:0] idx;

    assign in_range = req_addr[xlen-1:ram_byte_w] == '0;
    assign idx      = req_addr[ram_byte_w-1:2];
    assign pending  = cnt != '0;

    // array access happens on the accepting edge, data is held until data_valid
    always_ff @(posedge clk) begin
        if (req_valid && in_range) begin
            if (req_op) begin
                for (int i = 0; i < strb_w; i++) begin
                    if (req_strb[i])
                        mem[idx][8*i +: 8] <= req_wdata[8*i +: 8];
                end
                r_data <= '0;  // nothing to return for a store
            end else begin
                r_data <= mem[idx];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt           <= '0;
            data_valid    <= 1'b0;
            ram_exception <= '0;
            ram_badv      <= '0;
        end else begin
            data_valid    <= pending && cnt == ram_lat_w'(1);
            ram_exception <= '0;
            ram_badv      <= '0;
            if (req_valid && in_range)
                cnt <= ram_latency - ram_lat_w'(1);
            else if (pending)
                cnt <= cnt - ram_lat_w'(1);
            // out of range, dropped and flagged next cycle
            if (req_valid && !in_range) begin
                ram_exception[exp_adem] <= 1'b1;
                ram_badv                <= req_addr;
            end
        end
    end

    // the stall upstream must keep the port quiet while busy
    a_no_req_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        pending |-> !req_valid
    ) else $error("request arrived while a response is pending");

endmodule

`default_nettype wire

// File: hdl/mem_pipe_reg.sv
`timescale 1ns/1ns
`default_nettype none

module mem_pipe_reg
    import mem_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  stall,
    input  wire logic                  s0_en,
    input  wire logic [reg_addr_w-1:0] s0_rd,
    input  wire logic [exp_w-1:0]      s0_exp,
    input  wire logic [xlen-1:0]       s0_addr,
    input  wire logic [1:0]            s0_width,
    input  wire logic                  s0_sign,
    output logic                       s1_en,
    output logic [reg_addr_w-1:0]      s1_rd,
    output logic [exp_w-1:0]           s1_exp,
    output logic [xlen-1:0]            s1_addr,
    output logic [1:0]                 s1_width,
    output logic                       s1_sign
);

    // entry control, empty after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_en  <= 1'b0;
            s1_rd  <= '0;
            s1_exp <= '0;
        end else if (!stall) begin
            s1_en  <= s0_en;
            s1_rd  <= s0_rd;
            s1_exp <= s0_exp;
        end
    end

    // access payload
    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_addr  <= s0_addr;
            s1_width <= s0_width;
            s1_sign  <= s0_sign;
        end
    end

    // response stage still needs the same access while it waits
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall |=> $stable({s1_en, s1_rd, s1_exp, s1_addr, s1_width, s1_sign})
    ) else $error("stage 1 entry changed during stall");

endmodule

`default_nettype wire

// File: hdl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // datapath geometry
    localparam int unsigned xlen       = 32;
    localparam int unsigned reg_addr_w = 5;
    localparam int unsigned strb_w     = xlen / 8;  // one strobe per byte lane

    // exception vector, one bit per cause
    localparam int unsigned exp_w    = 7;
    localparam int unsigned exp_ale  = 3;  // misaligned halfword or word
    localparam int unsigned exp_adem = 4;  // address beyond the data RAM

    // access width codes, same values as the core's decode
    localparam logic [1:0] width_byte = 2'd0;
    localparam logic [1:0] width_half = 2'd1;
    localparam logic [1:0] width_word = 2'd2;

    // data RAM geometry
    localparam int unsigned ram_words  = 256;
    localparam int unsigned ram_addr_w = $clog2(ram_words);  // word index bits
    localparam int unsigned ram_byte_w = ram_addr_w + 2;     // byte address bits, 0..1023

    // response delay, counted from the accepting edge
    localparam int unsigned        ram_lat_w   = 2;
    localparam logic [ram_lat_w-1:0] ram_latency = 2'd2;

    // returned word, read either as byte lanes or as halfword lanes
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } load_word_t;

endpackage

`default_nettype wire

// File: hdl/mem_req_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_req_stage
    import mem_pkg::*;
(
    input  wire logic                  in_en,
    input  wire logic [reg_addr_w-1:0] in_rd,
    input  wire logic [xlen-1:0]       in_base,
    input  wire logic [xlen-1:0]       in_imm,
    input  wire logic [xlen-1:0]       in_store_data,
    input  wire logic                  in_write,
    input  wire logic [1:0]            in_width,
    input  wire logic                  in_sign,
    input  wire logic [exp_w-1:0]      in_exp,
    input  wire logic                  stall,
    output logic                       req_valid,
    output logic                       req_op,    // 1 write, 0 read
    output logic [xlen-1:0]            req_addr,
    output logic [strb_w-1:0]          req_strb,
    output logic [xlen-1:0]            req_wdata,
    output logic                       s0_en,
    output logic [reg_addr_w-1:0]      s0_rd,
    output logic [exp_w-1:0]           s0_exp,
    output logic [xlen-1:0]            s0_addr,
    output logic [1:0]                 s0_width,
    output logic                       s0_sign
);

    logic [xlen-1:0]   addr;
    logic [strb_w-1:0] mask;
    logic              misalign;

    assign addr = in_base + in_imm;

    // lane mask, alignment rule and store lane replication per width
    always_comb begin
        case (in_width)
            width_byte: begin
                mask      = 4'b0001;
                misalign  = 1'b0;
                req_wdata = {4{in_store_data[7:0]}};
            end
            width_half: begin
                mask      = 4'b0011;
                misalign  = addr[0];
                req_wdata = {2{in_store_data[15:0]}};
            end
            default: begin  // reserved code falls back to word
                mask      = 4'b1111;
                misalign  = |addr[1:0];
                req_wdata = in_store_data;
            end
        endcase
        // an access that passes the alignment rule keeps all its lanes in the word
        assert (!in_en || misalign ||
                (({{strb_w{1'b0}}, mask} << addr[1:0]) >> strb_w) == '0)
            else $error("aligned access shifted a byte lane off the top of the strobe");
    end

    assign req_strb  = mask << addr[1:0];
    assign req_addr  = addr;
    assign req_op    = in_write;
    assign req_valid = in_en & ~misalign & ~stall;  // only while the pipe register moves

    always_comb begin
        s0_exp = in_exp;
        if (in_en && misalign)
            s0_exp[exp_ale] = 1'b1;
    end

    assign s0_en    = in_en;
    assign s0_rd    = in_en ? in_rd : '0;
    assign s0_addr  = addr;
    assign s0_width = in_width;
    assign s0_sign  = in_sign;

endmodule

`default_nettype wire

// File: hdl/mem_resp_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_resp_stage
    import mem_pkg::*;
(
    input  wire logic                  s1_en,
    input  wire logic [reg_addr_w-1:0] s1_rd,
    input  wire logic [exp_w-1:0]      s1_exp,
    input  wire logic [xlen-1:0]       s1_addr,
    input  wire logic [1:0]            s1_width,
    input  wire logic                  s1_sign,
    input  wire logic                  data_valid,
    input  wire logic [xlen-1:0]       r_data,
    input  wire logic [exp_w-1:0]      ram_exception,
    input  wire logic [xlen-1:0]       ram_badv,
    output logic                       stall,
    output logic                       wb_en,
    output logic [reg_addr_w-1:0]      wb_rd,
    output logic [xlen-1:0]            wb_data,
    output logic [exp_w-1:0]           wb_exp,
    output logic [xlen-1:0]            wb_badv
);

    load_word_t      word;
    logic [7:0]      sel_b;
    logic [15:0]     sel_h;
    logic [xlen-1:0] ext;
    logic            ale_hit;

    assign ale_hit = s1_en & s1_exp[exp_ale];  // never sent to the RAM

    // wait for the RAM unless it answered or the access never left
    assign stall = s1_en & ~ale_hit & ~(data_valid | (|ram_exception));

    assign wb_en  = s1_en & ~stall;
    assign wb_rd  = s1_en ? s1_rd : '0;
    assign wb_exp = s1_exp | ram_exception;

    always_comb begin
        if (ale_hit)
            wb_badv = s1_addr;
        else if (ram_exception[exp_adem])
            wb_badv = ram_badv;
        else
            wb_badv = '0;
    end

    // lane pick by the low address bits
    assign word  = r_data;
    assign sel_b = word.b[s1_addr[1:0]];
    assign sel_h = word.h[s1_addr[1]];

    always_comb begin
        case (s1_width)
            width_byte: ext = {{(xlen-8){s1_sign & sel_b[7]}}, sel_b};
            width_half: ext = {{(xlen-16){s1_sign & sel_h[15]}}, sel_h};
            width_word: ext = word;
            default:    ext = '0;  // reserved width returns nothing
        endcase
    end

    assign wb_data = (s1_en && data_valid && wb_exp == '0) ? ext : '0;

endmodule

`default_nettype wire

// File: hdl/mem_stage_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage_top
    import mem_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  in_en,
    input  wire logic [reg_addr_w-1:0] in_rd,
    input  wire logic [xlen-1:0]       in_base,
    input  wire logic [xlen-1:0]       in_imm,
    input  wire logic [xlen-1:0]       in_store_data,
    input  wire logic                  in_write,
    input  wire logic [1:0]            in_width,
    input  wire logic                  in_sign,
    input  wire logic [exp_w-1:0]      in_exp,
    output logic                       stall,
    output logic                       wb_en,
    output logic [reg_addr_w-1:0]      wb_rd,
    output logic [xlen-1:0]            wb_data,
    output logic [exp_w-1:0]           wb_exp,
    output logic [xlen-1:0]            wb_badv
);

    // RAM request and response
    logic              req_valid;
    logic              req_op;
    logic [xlen-1:0]   req_addr;
    logic [strb_w-1:0] req_strb;
    logic [xlen-1:0]   req_wdata;
    logic              data_valid;
    logic [xlen-1:0]   r_data;
    logic [exp_w-1:0]  ram_exception;
    logic [xlen-1:0]   ram_badv;

    // stage 0 to stage 1
    logic                  s0_en,    s1_en;
    logic [reg_addr_w-1:0] s0_rd,    s1_rd;
    logic [exp_w-1:0]      s0_exp,   s1_exp;
    logic [xlen-1:0]       s0_addr,  s1_addr;
    logic [1:0]            s0_width, s1_width;
    logic                  s0_sign,  s1_sign;

    mem_req_stage u_req (
        .in_en, .in_rd, .in_base, .in_imm, .in_store_data,
        .in_write, .in_width, .in_sign, .in_exp, .stall,
        .req_valid, .req_op, .req_addr, .req_strb, .req_wdata,
        .s0_en, .s0_rd, .s0_exp, .s0_addr, .s0_width, .s0_sign
    );

    mem_pipe_reg u_pipe (
        .clk, .rst_n, .stall,
        .s0_en, .s0_rd, .s0_exp, .s0_addr, .s0_width, .s0_sign,
        .s1_en, .s1_rd, .s1_exp, .s1_addr, .s1_width, .s1_sign
    );

    data_ram_ctrl u_ram (
        .clk, .rst_n,
        .req_valid, .req_op, .req_addr, .req_strb, .req_wdata,
        .data_valid, .r_data, .ram_exception, .ram_badv
    );

    mem_resp_stage u_resp (
        .s1_en, .s1_rd, .s1_exp, .s1_addr, .s1_width, .s1_sign,
        .data_valid, .r_data, .ram_exception, .ram_badv,
        .stall, .wb_en, .wb_rd, .wb_data, .wb_exp, .wb_badv
    );

endmodule

`default_nettype wire

// File: verif/mem_stage_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage_tb
    import mem_pkg::*;
();

    localparam int ncol         = 13;  // hex fields per stimulus line
    localparam int max_lines    = 64;
    localparam int accept_limit = 20;  // cycles a line may sit at the inputs
    localparam int drain_limit  = 40;

    logic                  clk;
    logic                  rst_n;
    logic                  in_en;
    logic [reg_addr_w-1:0] in_rd;
    logic [xlen-1:0]       in_base;
    logic [xlen-1:0]       in_imm;
    logic [xlen-1:0]       in_store_data;
    logic                  in_write;
    logic [1:0]            in_width;
    logic                  in_sign;
    logic [exp_w-1:0]      in_exp;
    logic                  stall;
    logic                  wb_en;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_data;
    logic [exp_w-1:0]      wb_exp;
    logic [xlen-1:0]       wb_badv;

    logic [31:0] stim [max_lines*ncol];
    integer      seed       = 32'h1e2d34bf;
    int          drv_line   = -1;  // line on the inputs, -1 when idle
    int          s1_line    = -1;  // line the monitor sees in stage 1
    int          s1_wait    = 0;
    int          chk_line   = -1;
    int          done_count = 0;
    int          wb_count   = 0;
    int          n_lines;
    int          n_mem;

    mem_stage_top dut0 (
        .clk, .rst_n,
        .in_en, .in_rd, .in_base, .in_imm, .in_store_data,
        .in_write, .in_width, .in_sign, .in_exp,
        .stall, .wb_en, .wb_rd, .wb_data, .wb_exp, .wb_badv
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] field(input int idx, input int col);
        return stim[idx*ncol + col];
    endfunction

    // a RAM access waits latency-1 cycles, ALE and ADEM entries never wait
    function automatic int stall_cycles(input int idx);
        logic [exp_w-1:0] e;
        e = exp_w'(field(idx, 11));
        if (field(idx, 0) != 0 && !e[exp_ale] && !e[exp_adem])
            return int'(ram_latency) - 1;
        return 0;
    endfunction

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("FAIL %s got %h expected %h, stimulus line %0d", name, got, want, chk_line);
            abort_run();
        end
    endtask

    task automatic check_rd(input string name, input logic [reg_addr_w-1:0] got,
                            input logic [reg_addr_w-1:0] want);
        if (got !== want) begin
            $display("FAIL %s got %h expected %h, stimulus line %0d", name, got, want, chk_line);
            abort_run();
        end
    endtask

    task automatic check_exp(input string name, input logic [exp_w-1:0] got,
                             input logic [exp_w-1:0] want);
        if (got !== want) begin
            $display("FAIL %s got %h expected %h, stimulus line %0d", name, got, want, chk_line);
            abort_run();
        end
    endtask

    task automatic check_data(input string name, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] want);
        load_word_t g;
        load_word_t w;
        int         lane;
        g    = got;
        w    = want;
        lane = -1;
        if (got !== want) begin
            for (int i = strb_w - 1; i >= 0; i--) begin
                if (g.b[i] !== w.b[i])
                    lane = i;  // lowest differing byte wins
            end
            $display("FAIL %s got %h expected %h, first bad byte lane %0d, stimulus line %0d",
                     name, got, want, lane, chk_line);
            abort_run();
        end
    endtask

    task automatic apply_line(input int idx);
        in_en         <= field(idx, 0) != 0;
        in_rd         <= reg_addr_w'(field(idx, 1));
        in_base       <= field(idx, 2);
        in_imm        <= field(idx, 3);
        in_store_data <= field(idx, 4);
        in_write      <= field(idx, 5) != 0;
        in_width      <= 2'(field(idx, 6));
        in_sign       <= field(idx, 7) != 0;
        in_exp        <= exp_w'(field(idx, 8));
        drv_line      <= idx;
    endtask

    task automatic apply_idle();
        in_en         <= 1'b0;
        in_rd         <= '0;
        in_base       <= '0;
        in_imm        <= '0;
        in_store_data <= '0;
        in_write      <= 1'b0;
        in_width      <= width_byte;
        in_sign       <= 1'b0;
        in_exp        <= '0;
        drv_line      <= -1;
    endtask

    // line is taken on the first edge that sees stall low
    task automatic wait_accept(input int idx);
        int waited;
        waited = 0;
        @(posedge clk);
        while (stall) begin
            waited++;
            if (waited > accept_limit) begin
                $display("timeout waiting for stall to drop, line %0d never accepted", idx);
                abort_run();
            end
            @(posedge clk);
        end
    endtask

    task automatic compare_line(input int idx);
        check_flag("wb_en", wb_en, field(idx, 0) != 0);
        check_rd("wb_rd", wb_rd, reg_addr_w'(field(idx, 9)));
        check_data("wb_data", wb_data, field(idx, 10));
        check_exp("wb_exp", wb_exp, exp_w'(field(idx, 11)));
        check_data("wb_badv", wb_badv, field(idx, 12));
    endtask

    // writeback monitor, values read at the edge are the settled pre-edge ones
    always @(posedge clk) begin
        if (rst_n) begin
            chk_line = s1_line;
            if (wb_en)
                wb_count <= wb_count + 1;
            if (s1_line < 0) begin  // idle entry
                check_flag("wb_en", wb_en, 1'b0);
                check_flag("stall", stall, 1'b0);
            end else if (s1_wait < stall_cycles(s1_line)) begin
                check_flag("stall", stall, 1'b1);
                s1_wait++;
            end else begin
                check_flag("stall", stall, 1'b0);
                compare_line(s1_line);
                done_count <= done_count + 1;
            end
            if (!stall) begin  // stage 1 takes whatever the inputs hold
                s1_line = drv_line;
                s1_wait = 0;
            end
        end
    end

    initial begin
        int gap;
        int waited;
        rst_n = 1'b0;
        apply_idle();
        $readmemh("verif/mem_stimulus.txt", stim);
        n_lines = 0;
        while (n_lines < max_lines && stim[n_lines*ncol] !== 'x)
            n_lines++;
        if (n_lines == 0) begin
            $display("stimulus file verif/mem_stimulus.txt holds no access lines");
            abort_run();
        end
        n_mem = 0;
        for (int i = 0; i < n_lines; i++) begin
            if (field(i, 0) != 0)
                n_mem++;
        end

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        for (int i = 0; i < n_lines; i++) begin
            apply_line(i);
            wait_accept(i);
            gap = $unsigned($random(seed)) % 4;
            if (gap == 3)
                gap = 0;  // keep most lines back to back
            if (gap != 0) begin
                apply_idle();
                repeat (gap) @(posedge clk);
            end
        end
        apply_idle();

        waited = 0;
        while (done_count < n_lines) begin
            @(posedge clk);
            waited++;
            if (waited > drain_limit) begin
                $display("timeout waiting for the last writebacks, %0d of %0d lines done",
                         done_count, n_lines);
                abort_run();
            end
        end
        repeat (2) @(posedge clk);  // idle entries only from here

        if (wb_count == n_mem) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("FAIL wb_count got %h expected %h", wb_count, n_mem);
            abort_run();
        end
    end

endmodule

`default_nettype wire

// File: verif/mem_stimulus.txt
// en rd base imm store_data write width sign in_exp, then wb_rd wb_data wb_exp wb_badv
// all hex, one access per line; width 0 byte, 1 halfword, 2 word
1 00 00000100 00000000 deadbeef 1 2 0 00  00 00000000 00 00000000
1 05 00000100 00000000 00000000 0 2 0 00  05 deadbeef 00 00000000
1 00 00000100 00000004 12345681 1 0 0 00  00 00000000 00 00000000
1 00 00000104 00000001 abcdef7f 1 0 0 00  00 00000000 00 00000000
1 00 00000108 fffffffe 000000c3 1 0 0 00  00 00000000 00 00000000
1 00 00000100 00000007 ffffff25 1 0 0 00  00 00000000 00 00000000
1 01 00000104 00000000 00000000 0 0 1 00  01 ffffff81 00 00000000
1 02 00000104 00000000 00000000 0 0 0 00  02 00000081 00 00000000
1 03 00000104 00000001 00000000 0 0 1 00  03 0000007f 00 00000000
1 04 00000104 00000002 00000000 0 0 1 00  04 ffffffc3 00 00000000
1 06 00000104 00000003 00000000 0 0 0 00  06 00000025 00 00000000
1 08 00000104 00000000 00000000 0 2 0 00  08 25c37f81 00 00000000
1 00 00000108 00000000 aaaa8001 1 1 0 00  00 00000000 00 00000000
1 00 00000108 00000002 55557ffe 1 1 0 00  00 00000000 00 00000000
1 0a 00000108 00000000 00000000 0 1 1 00  0a ffff8001 00 00000000
1 0b 00000108 00000000 00000000 0 1 0 00  0b 00008001 00 00000000
1 0c 00000108 00000002 00000000 0 1 1 00  0c 00007ffe 00 00000000
1 0d 00000108 00000000 00000000 0 2 0 00  0d 7ffe8001 00 00000000
1 0e 00000108 00000001 00000000 0 0 1 00  0e ffffff80 00 00000000
1 00 00000100 00000001 11111111 1 2 0 00  00 00000000 08 00000101
1 10 00000104 00000001 00000000 0 1 1 00  10 00000000 08 00000105
1 11 00000100 00000002 00000000 0 2 0 00  11 00000000 08 00000102
1 00 00000100 00000003 0000ffff 1 1 0 00  00 00000000 08 00000103
1 12 00000108 00000005 00000000 0 1 0 01  12 00000000 09 0000010d
1 13 00000100 00000000 00000000 0 2 0 00  13 deadbeef 00 00000000
1 14 00000104 00000000 00000000 0 2 0 00  14 25c37f81 00 00000000
1 15 00000400 00000000 00000000 0 2 0 00  15 00000000 10 00000400
1 00 00000000 fffffffc 000000aa 1 0 0 00  00 00000000 10 fffffffc
1 16 000003fe 00000002 00000000 0 1 1 00  16 00000000 10 00000400
1 17 00001000 00000001 00000000 0 2 0 00  17 00000000 08 00001001
1 00 00000400 fffffffc cafef00d 1 2 0 00  00 00000000 00 00000000
1 18 000003f0 0000000c 00000000 0 2 0 00  18 cafef00d 00 00000000
0 07 00000000 00000000 00000000 0 0 0 40  00 00000000 40 00000000
0 1f 00000103 00000000 00000000 0 2 0 05  00 00000000 05 00000000
1 19 00000100 00000000 00000000 0 2 0 02  19 00000000 02 00000000
1 1a 00000104 00000001 00000000 0 0 1 00  1a 0000007f 00 00000000
1 1b 000003fc 00000000 00000000 0 1 1 00  1b fffff00d 00 00000000
1 1c 00000100 00000000 00000000 0 2 0 00  1c deadbeef 00 00000000
